//--- all.f
verilog/hazard_pkg.sv
verilog/ins_decode.sv
verilog/stage_track.sv
verilog/hazard_det.sv
verilog/fetch_ctl.sv
verilog/hazard_top.sv
bench/hazard_assert.sv
bench/tb_hazard_top.sv

//--- Bender.yml
package:
  name: hazard_ctl

sources:
  - verilog/hazard_pkg.sv
  - verilog/ins_decode.sv
  - verilog/stage_track.sv
  - verilog/hazard_det.sv
  - verilog/fetch_ctl.sv
  - verilog/hazard_top.sv
  - target: test
    files:
      - bench/hazard_assert.sv
      - bench/tb_hazard_top.sv

//--- bench/tb_hazard_top.sv
`timescale 1ns/1ps

module tb_hazard_top;

  localparam hazard_pkg::addr_t RESET_PC = 16'h0100;
  localparam int NUM_CYCLES = 3000;

  // instruction classes the stimulus draws from where the last entry is no opcode at all
  localparam hazard_pkg::opcode_t OP_TABLE [16] = '{
    hazard_pkg::OP_JR, hazard_pkg::OP_JAL, hazard_pkg::OP_JALR, hazard_pkg::OP_STORE,
    hazard_pkg::OP_LOAD, hazard_pkg::OP_SLBI, hazard_pkg::OP_STU, hazard_pkg::OP_LBI,
    hazard_pkg::OP_ADDI, hazard_pkg::OP_ANDNI, hazard_pkg::OP_BEQZ, hazard_pkg::OP_BGEZ,
    hazard_pkg::OP_RTYPE, hazard_pkg::OP_SEQ, hazard_pkg::OP_SCO, 5'b00000
  };
  // few registers so that readers keep running into older writers
  localparam hazard_pkg::reg_idx_t REG_TABLE [4] = '{3'd1, 3'd2, 3'd5, hazard_pkg::R7};

  logic                  clk;
  logic                  rst_n;
  logic                  ins_valid;
  hazard_pkg::ins_word_t ins;
  hazard_pkg::pc_src_t   pc_source;
  hazard_pkg::addr_t     branch_target;
  logic                  stall_decode;
  logic                  flush_fetch;
  logic                  issue;
  hazard_pkg::addr_t     pc;

  logic [15:0]       lfsr_state;
  hazard_pkg::dest_t m_ex;   // model of the execute slot
  hazard_pkg::dest_t m_mem;  // model of the memory slot
  hazard_pkg::addr_t m_pc;   // model of the fetch pc after the last rising edge

  hazard_top #(.RESET_PC(RESET_PC)) u_hazard_top (
    .clk(clk), .rst_n(rst_n), .ins_valid(ins_valid), .ins(ins), .pc_source(pc_source),
    .branch_target(branch_target), .stall_decode(stall_decode), .flush_fetch(flush_fetch),
    .issue(issue), .pc(pc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr on x^16 + x^14 + x^13 + x^11 + 1 that steps once per bit handed out
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] time=%0t signal=%s actual=%h expected=%h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "%s", reason);
  endtask

  // true when a valid older instruction still has to write register r
  function automatic logic written_ahead(input hazard_pkg::reg_idx_t r);
    return (m_ex.valid && m_ex.idx == r) || (m_mem.valid && m_mem.idx == r);
  endfunction

  // reads and writes of one instruction taken straight from the decode table
  task automatic decode_model(input hazard_pkg::ins_word_t w,
                              output hazard_pkg::read_set_t rd_set,
                              output hazard_pkg::dest_t d);
    hazard_pkg::opcode_t op;
    op = w[15:11];
    rd_set = '0;
    rd_set.rs = w[10:8];
    rd_set.rt = w[7:5];
    rd_set.rd = w[7:5];  // store data sits in the second field
    d = '0;
    case (op) inside
      hazard_pkg::OP_STORE, hazard_pkg::OP_STU: begin
        rd_set.use_rs = 1'b1;
        rd_set.use_rd = 1'b1;
        d.idx = w[10:8];
        d.valid = (op == hazard_pkg::OP_STU);  // only stu updates its base
      end
      hazard_pkg::OP_LOAD, [hazard_pkg::OP_ADDI:hazard_pkg::OP_ANDNI]: begin
        rd_set.use_rs = 1'b1;
        d = '{idx: w[7:5], valid: 1'b1};
      end
      hazard_pkg::OP_SLBI: begin
        rd_set.use_rs = 1'b1;
        d = '{idx: w[10:8], valid: 1'b1};
      end
      hazard_pkg::OP_LBI: d = '{idx: w[10:8], valid: 1'b1};  // reads nothing
      hazard_pkg::OP_JAL: d = '{idx: hazard_pkg::R7, valid: 1'b1};
      hazard_pkg::OP_JALR: begin
        rd_set.use_rs = 1'b1;
        d = '{idx: hazard_pkg::R7, valid: 1'b1};
      end
      hazard_pkg::OP_JR, [hazard_pkg::OP_BEQZ:hazard_pkg::OP_BGEZ]: rd_set.use_rs = 1'b1;
      hazard_pkg::OP_RTYPE, [hazard_pkg::OP_SEQ:hazard_pkg::OP_SCO]: begin
        rd_set.use_rs = 1'b1;
        rd_set.use_rt = 1'b1;
        d = '{idx: w[4:2], valid: 1'b1};
      end
      default: d = '0;
    endcase
  endtask

  // hard limit on simulated time in case the clock loop never ends
  initial begin
    #((NUM_CYCLES + 100) * 40);
    abort_run("simulation ran past its cycle budget without finishing");
  end

  initial begin
    hazard_pkg::read_set_t exp_rd;
    hazard_pkg::dest_t     exp_dest;
    logic                  exp_stall;
    logic                  exp_flush;
    logic                  exp_issue;
    logic                  hold;
    lfsr_state = 16'd36704;
    rst_n = 1'b0;
    ins_valid = 1'b0;
    ins = '0;
    pc_source = hazard_pkg::PC_SEQ;
    branch_target = '0;
    m_ex = '0;  // both slots start as bubbles
    m_mem = '0;
    m_pc = RESET_PC;
    hold = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      compare_value("pc", pc, m_pc);  // settled since the last rising edge
      if (!hold) begin  // a stalled instruction stays in decode
        ins_valid = (rand_bits(3) != 16'd0);
        ins = rand_bits(16);
        ins[15:11] = OP_TABLE[rand_bits(4)];
        ins[10:8] = REG_TABLE[rand_bits(2)];
        ins[7:5] = REG_TABLE[rand_bits(2)];
        ins[4:2] = REG_TABLE[rand_bits(2)];
      end
      pc_source = hazard_pkg::pc_src_t'(rand_bits(2));  // the spare codes also mean sequential
      if (rand_bits(3) == 16'd0) begin
        pc_source = hazard_pkg::PC_REDIRECT;
      end else if (pc_source == hazard_pkg::PC_REDIRECT) begin
        pc_source = hazard_pkg::PC_SEQ;
      end
      branch_target = rand_bits(16) & 16'hfffe;
      #1;
      decode_model(ins, exp_rd, exp_dest);
      exp_stall = ins_valid && ((exp_rd.use_rs && written_ahead(exp_rd.rs)) ||
                                (exp_rd.use_rt && written_ahead(exp_rd.rt)) ||
                                (exp_rd.use_rd && written_ahead(exp_rd.rd)));
      exp_flush = (pc_source == hazard_pkg::PC_REDIRECT);
      exp_issue = ins_valid && !exp_stall && !exp_flush;
      compare_value("stall_decode", stall_decode, exp_stall);
      compare_value("flush_fetch", flush_fetch, exp_flush);
      compare_value("issue", issue, exp_issue);
      if (u_hazard_top.u_hazard_assert.fail_count != 0) begin
        abort_run("a bound assertion on hazard_top failed");
      end
      hold = exp_stall && !exp_flush;  // a flushed instruction is dropped
      m_mem = m_ex;  // slots advance every edge and a stall or flush leaves a bubble
      m_ex.idx = exp_dest.idx;
      m_ex.valid = exp_issue && exp_dest.valid;
      if (exp_flush) begin
        m_pc = branch_target;  // redirect beats the stall
      end else if (!exp_stall) begin
        m_pc = m_pc + 16'd2;
      end
      @(negedge clk);
    end
    if (u_hazard_top.u_hazard_assert.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "bound assertions failed in the last cycle");
    end
  end

endmodule

//--- bench/hazard_assert.sv
`timescale 1ns/1ps

module hazard_assert (
  input logic              clk,
  input logic              rst_n,
  input logic              stall_decode,
  input logic              flush_fetch,
  input logic              issue,
  input hazard_pkg::addr_t pc
);

  int fail_count = 0;  // number of failed assertions so far

  // an instruction only moves into execute when nothing holds it back
  issue_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      issue |-> !(stall_decode || flush_fetch))
    else begin
      $error("issue high together with stall_decode or flush_fetch");
      fail_count++;
    end

  // decode is held, so fetch must refetch the same word
  pc_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (stall_decode && !flush_fetch) |=> (pc == $past(pc)))
    else begin
      $error("pc moved across a stall without a redirect");
      fail_count++;
    end

  // reset leaves both slots empty so nothing can stall right after it
  no_stall_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall_decode)
    else begin
      $error("stall_decode high in the first cycle after reset");
      fail_count++;
    end

endmodule

bind hazard_top hazard_assert u_hazard_assert (
  .clk(clk), .rst_n(rst_n), .stall_decode(stall_decode), .flush_fetch(flush_fetch),
  .issue(issue), .pc(pc)
);

//--- verilog/hazard_top.sv
`timescale 1ns/1ps

module hazard_top #(
  parameter hazard_pkg::addr_t RESET_PC = 16'h0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ins_valid,
  input  hazard_pkg::ins_word_t ins,
  input  hazard_pkg::pc_src_t   pc_source,
  input  hazard_pkg::addr_t     branch_target,
  output logic                  stall_decode,
  output logic                  flush_fetch,
  output logic                  issue,
  output hazard_pkg::addr_t     pc
);

  hazard_pkg::read_set_t rd_set;      // registers read by the decode instruction
  hazard_pkg::dest_t     dest;        // register it would write
  hazard_pkg::dest_t     issue_dest;  // dest once it really enters execute
  hazard_pkg::dest_t     slot_ex;
  hazard_pkg::dest_t     slot_mem;

  ins_decode u_ins_decode (.ins(ins), .rd_set(rd_set), .dest(dest));

  stage_track u_stage_track (
    .clk(clk), .rst_n(rst_n), .issue(issue), .issue_dest(issue_dest),
    .slot_ex(slot_ex), .slot_mem(slot_mem)
  );

  hazard_det u_hazard_det (
    .ins_valid(ins_valid), .rd_set(rd_set), .dest(dest), .slot_ex(slot_ex),
    .slot_mem(slot_mem), .pc_source(pc_source), .stall_decode(stall_decode),
    .flush_fetch(flush_fetch), .issue(issue), .issue_dest(issue_dest)
  );

  fetch_ctl #(.RESET_PC(RESET_PC)) u_fetch_ctl (
    .clk(clk), .rst_n(rst_n), .stall_decode(stall_decode), .pc_source(pc_source),
    .branch_target(branch_target), .pc(pc)
  );

endmodule

//--- verilog/fetch_ctl.sv
`timescale 1ns/1ps

module fetch_ctl #(
  parameter hazard_pkg::addr_t RESET_PC = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall_decode,
  input  hazard_pkg::pc_src_t pc_source,
  input  hazard_pkg::addr_t   branch_target,
  output hazard_pkg::addr_t   pc
);

  hazard_pkg::addr_t pc_next;
  logic              redirect;

  assign redirect = (pc_source == hazard_pkg::PC_REDIRECT);

  // redirect wins over a stall since the stalled instruction is being flushed anyway
  always_comb begin
    if (redirect) begin
      pc_next = branch_target;
    end else if (stall_decode) begin
      pc_next = pc;  // refetch the same word while decode is held
    end else begin
      pc_next = pc + hazard_pkg::addr_t'(2);  // instructions are two bytes wide
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- verilog/hazard_det.sv
`timescale 1ns/1ps

module hazard_det (
  input  logic                  ins_valid,
  input  hazard_pkg::read_set_t rd_set,
  input  hazard_pkg::dest_t     dest,
  input  hazard_pkg::dest_t     slot_ex,
  input  hazard_pkg::dest_t     slot_mem,
  input  hazard_pkg::pc_src_t   pc_source,
  output logic                  stall_decode,
  output logic                  flush_fetch,
  output logic                  issue,
  output hazard_pkg::dest_t     issue_dest
);

  logic rs_hit;  // rs is read and an older writer still owns it
  logic rt_hit;  // second r-type source collides
  logic rd_hit;  // store data register collides
  logic raw_hazard;

  // true when the slot holds a real writer of register idx
  function automatic logic slot_writes(input hazard_pkg::dest_t slot,
                                       input hazard_pkg::reg_idx_t idx);
    slot_writes = slot.valid && (slot.idx == idx);
  endfunction

  // every used read field is checked against both older stages
  assign rs_hit = rd_set.use_rs &&
                  (slot_writes(slot_ex, rd_set.rs) || slot_writes(slot_mem, rd_set.rs));
  assign rt_hit = rd_set.use_rt &&
                  (slot_writes(slot_ex, rd_set.rt) || slot_writes(slot_mem, rd_set.rt));
  assign rd_hit = rd_set.use_rd &&
                  (slot_writes(slot_ex, rd_set.rd) || slot_writes(slot_mem, rd_set.rd));

  // jal and jalr sit in the slots as writers of r7 so the link register needs no special case
  assign raw_hazard = rs_hit | rt_hit | rd_hit;

  // there is no forwarding so a reader waits in decode until the writer has left memory
  assign stall_decode = ins_valid & raw_hazard;

  // execute took a branch or jump so the instruction in decode is on the wrong path
  assign flush_fetch = (pc_source == hazard_pkg::PC_REDIRECT);

  // only a clean, valid, on-path instruction moves into execute
  assign issue = ins_valid & ~stall_decode & ~flush_fetch;

  // the destination goes down the pipe only with its instruction
  assign issue_dest.idx   = dest.idx;
  assign issue_dest.valid = dest.valid & issue;  // anything else turns into a bubble

endmodule

//--- verilog/stage_track.sv
`timescale 1ns/1ps

module stage_track (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue,
  input  hazard_pkg::dest_t issue_dest,
  output hazard_pkg::dest_t slot_ex,
  output hazard_pkg::dest_t slot_mem
);

  // destinations of the two older instructions where execute holds the younger one
  hazard_pkg::reg_idx_t ex_idx;
  hazard_pkg::reg_idx_t mem_idx;
  logic                 ex_valid;
  logic                 mem_valid;

  // valid flags are the only control state and a cleared flag makes the slot a bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid  <= 1'b0;
      mem_valid <= 1'b0;
    end else begin
      ex_valid  <= issue & issue_dest.valid;  // stall or flush leaves a bubble behind
      mem_valid <= ex_valid;                  // execute always moves on since nothing pushes back
    end
  end

  // an index only means something while its valid flag is high
  always_ff @(posedge clk) begin
    ex_idx  <= issue_dest.idx;
    mem_idx <= ex_idx;
  end

  /*
   * a reader that collides with one of these waits for the writer to leave
   * the memory stage, which takes two edges at most since both slots advance
   * on every cycle whatever decode is doing
   */
  assign slot_ex.idx    = ex_idx;
  assign slot_ex.valid  = ex_valid;
  assign slot_mem.idx   = mem_idx;
  assign slot_mem.valid = mem_valid;

endmodule

//--- verilog/ins_decode.sv
`timescale 1ns/1ps

module ins_decode (
  input  hazard_pkg::ins_word_t ins,
  output hazard_pkg::read_set_t rd_set,
  output hazard_pkg::dest_t     dest
);

  hazard_pkg::opcode_t  opcode;
  hazard_pkg::reg_idx_t f_rs;  // bits 10 to 8
  hazard_pkg::reg_idx_t f_rt;  // bits 7 to 5 hold rt for r-type and rd for i-type and store data
  hazard_pkg::reg_idx_t f_rd;  // r-type destination in bits 4 to 2

  assign opcode = ins[15:11];
  assign f_rs   = ins[10:8];
  assign f_rt   = ins[7:5];
  assign f_rd   = ins[4:2];

  always_comb begin
    // the fields sit in fixed places and only the flags depend on the opcode
    rd_set.rs     = f_rs;
    rd_set.rt     = f_rt;
    rd_set.rd     = f_rt;  // store data shares the bits 7 to 5 field
    rd_set.use_rs = 1'b0;
    rd_set.use_rt = 1'b0;
    rd_set.use_rd = 1'b0;
    dest.idx      = f_rt;
    dest.valid    = 1'b0;  // unknown opcodes read and write nothing

    if (opcode == hazard_pkg::OP_STORE || opcode == hazard_pkg::OP_STU) begin
      rd_set.use_rs = 1'b1;  // base address
      rd_set.use_rd = 1'b1;  // data to be stored is needed in decode too
      dest.idx      = f_rs;
      dest.valid    = (opcode == hazard_pkg::OP_STU);  // stu writes the updated base back
    end else if (opcode == hazard_pkg::OP_LOAD ||
                 (opcode >= hazard_pkg::OP_ADDI && opcode <= hazard_pkg::OP_ANDNI)) begin
      rd_set.use_rs = 1'b1;
      dest.idx      = f_rt;
      dest.valid    = 1'b1;
    end else if (opcode == hazard_pkg::OP_SLBI) begin
      rd_set.use_rs = 1'b1;  // shift and or into rs itself
      dest.idx      = f_rs;
      dest.valid    = 1'b1;
    end else if (opcode == hazard_pkg::OP_LBI) begin
      dest.idx      = f_rs;  // no read at all so lbi can never stall
      dest.valid    = 1'b1;
    end else if (opcode == hazard_pkg::OP_JAL || opcode == hazard_pkg::OP_JALR) begin
      rd_set.use_rs = (opcode == hazard_pkg::OP_JALR);  // jalr jumps through rs
      dest.idx      = hazard_pkg::R7;  // return address goes to the link register
      dest.valid    = 1'b1;
    end else if (opcode == hazard_pkg::OP_JR ||
                 (opcode >= hazard_pkg::OP_BEQZ && opcode <= hazard_pkg::OP_BGEZ)) begin
      rd_set.use_rs = 1'b1;  // target or condition comes from rs and nothing is written
    end else if (opcode == hazard_pkg::OP_RTYPE ||
                 (opcode >= hazard_pkg::OP_SEQ && opcode <= hazard_pkg::OP_SCO)) begin
      rd_set.use_rs = 1'b1;
      rd_set.use_rt = 1'b1;
      dest.idx      = f_rd;
      dest.valid    = 1'b1;
    end
  end

endmodule

//--- verilog/hazard_pkg.sv
package hazard_pkg;

  // widths that carry a meaning in the decode stage
  typedef logic [15:0] ins_word_t;  // one instruction word
  typedef logic [4:0]  opcode_t;    // instruction bits 15 to 11
  typedef logic [2:0]  reg_idx_t;   // one of eight registers
  typedef logic [15:0] addr_t;      // byte granular fetch address
  typedef logic [1:0]  pc_src_t;    // program counter source chosen in execute

  localparam pc_src_t PC_SEQ      = 2'b00;  // fall through to pc + 2
  localparam pc_src_t PC_REDIRECT = 2'b10;  // taken branch or jump that flushes fetch

  // jumps
  localparam opcode_t OP_JR   = 5'b00101;
  localparam opcode_t OP_JAL  = 5'b00110;
  localparam opcode_t OP_JALR = 5'b00111;

  // memory and immediate loads
  localparam opcode_t OP_STORE = 5'b10000;
  localparam opcode_t OP_LOAD  = 5'b10001;
  localparam opcode_t OP_SLBI  = 5'b10010;
  localparam opcode_t OP_STU   = 5'b10011;
  localparam opcode_t OP_LBI   = 5'b11000;

  localparam opcode_t OP_ADDI  = 5'b01000;  // first of the i-type arithmetic group
  localparam opcode_t OP_ANDNI = 5'b01011;  // last of the i-type arithmetic group

  localparam opcode_t OP_BEQZ = 5'b01100;  // first branch on rs
  localparam opcode_t OP_BGEZ = 5'b01111;  // last branch on rs

  // every member of the r-type group writes the field in bits 4 to 2
  localparam opcode_t OP_RTYPE = 5'b11011;
  localparam opcode_t OP_SEQ   = 5'b11100;
  localparam opcode_t OP_SCO   = 5'b11111;

  localparam reg_idx_t R7 = 3'b111;  // link register written by jal and jalr

  // register reads of the instruction in decode
  typedef struct packed {
    reg_idx_t rs;      // bits 10 to 8
    reg_idx_t rt;      // second r-type source in bits 7 to 5
    reg_idx_t rd;      // store data register that also sits in bits 7 to 5
    logic     use_rs;
    logic     use_rt;
    logic     use_rd;
  } read_set_t;

  // destination register carried by one instruction down the pipe
  typedef struct packed {
    reg_idx_t idx;
    logic     valid;  // low for bubbles and for instructions that write nothing
  } dest_t;

endpackage
